//--- source/hs_pkg.sv
// shared definitions for the four-phase clock domain crossing
// holds the default word width and the state encodings of both sides
// imported by wildcard in each module header and in the testbench

package hs_pkg;

    // default width of one transferred word, in bits
    parameter int DATA_W = 32;

    // sending side states
    // one word in flight at a time, so three states are enough
    typedef enum logic [1:0] {
        TX_IDLE    = 2'b00,  // waiting for send strobe
        TX_REQ     = 2'b01,  // req up, waiting for synced ack
        TX_RELEASE = 2'b10   // req down, waiting for synced ack to fall
    } tx_state_e;

    // receiving side states, one-hot
    typedef enum logic [1:0] {
        RX_IDLE     = 2'b01,  // waiting for synced req
        RX_DEASSERT = 2'b10   // ack up, waiting for synced req to fall
    } rx_state_e;

    // protocol order seen on the wires, for reference
    //   req  rises   (sender, ack low)
    //   ack  rises   (receiver, synced req high)
    //   req  falls   (sender, synced ack high)
    //   ack  falls   (receiver, synced req low)
    // sender goes idle once synced ack is low again

endpackage

//--- source/full_handshake_tx.sv
// sending side of the four-phase handshake
// takes a word on a one-cycle send_i strobe while idle and holds it on
// req_data_o with req_o high until the acknowledge comes back
// send_done_o pulses once the acknowledge has fallen again
// strobes while busy_o is high are dropped

`timescale 1ns/1ps

module full_handshake_tx
    import hs_pkg::*;
#(
    parameter int DW = DATA_W  // word width in bits
) (
    input  logic          clk,          // sending domain clock
    input  logic          rst_n,        // sending domain reset, async low

    // local side
    input  logic          send_i,       // one-cycle send strobe
    input  logic [DW-1:0] send_data_i,  // word taken with send_i
    output logic          busy_o,       // word in flight
    output logic          send_done_o,  // one-cycle completion pulse

    // towards receiver
    output logic          req_o,        // request level
    output logic [DW-1:0] req_data_o,   // stable while req_o high

    // from receiver, other clock domain
    input  logic          ack_i
);

    tx_state_e state;
    tx_state_e state_next;

    logic          ack_d;      // first sync stage
    logic          ack_s;      // synced ack
    logic          req;
    logic          busy;
    logic          send_done;
    logic [DW-1:0] req_data;
    logic          accept;     // strobe taken this edge

    // only an idle sender takes a word, anything else is ignored
    assign accept = (state == TX_IDLE) && send_i;

    // two-flop synchronizer on the returning ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_d <= 1'b0;
            ack_s <= 1'b0;
        end else begin
            ack_d <= ack_i;
            ack_s <= ack_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= TX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            TX_IDLE: begin
                if (send_i) state_next = TX_REQ;        // word accepted
            end
            TX_REQ: begin
                if (ack_s) state_next = TX_RELEASE;     // receiver has it
            end
            TX_RELEASE: begin
                if (!ack_s) state_next = TX_IDLE;       // ack gone, done
            end
            default: begin
                state_next = TX_IDLE;
            end
        endcase
    end

    // control levels and the done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req       <= 1'b0;
            busy      <= 1'b0;
            send_done <= 1'b0;
        end else begin
            send_done <= 1'b0;  // pulse by default low
            case (state)
                TX_IDLE: begin
                    if (send_i) begin
                        req  <= 1'b1;  // high from next cycle
                        busy <= 1'b1;
                    end
                end
                TX_REQ: begin
                    if (ack_s) req <= 1'b0;  // drop on cycle after synced ack
                end
                TX_RELEASE: begin
                    if (!ack_s) begin
                        busy      <= 1'b0;  // falls together with done
                        send_done <= 1'b1;
                    end
                end
                default: begin
                    req  <= 1'b0;
                    busy <= 1'b0;
                end
            endcase
        end
    end

    // payload register, loaded only on acceptance
    always_ff @(posedge clk) begin
        if (accept) req_data <= send_data_i;
    end

    assign req_o       = req;
    assign req_data_o  = req_data;
    assign busy_o      = busy;
    assign send_done_o = send_done;

endmodule

//--- source/full_handshake_rx.sv
// receiving side of the four-phase handshake
// syncs the request through two flops, samples the data word and
// raises the acknowledge, with a one-cycle recv_rdy_o pulse
// recv_data_o is zero except during that pulse, no back-pressure

`timescale 1ns/1ps

module full_handshake_rx
    import hs_pkg::*;
#(
    parameter int DW = DATA_W  // word width in bits
) (
    input  logic          clk,          // receiving domain clock
    input  logic          rst_n,        // receiving domain reset, async low

    // from sender, other clock domain
    input  logic          req_i,        // request level
    input  logic [DW-1:0] req_data_i,   // held stable while req_i high

    // back to sender
    output logic          ack_o,

    // local side
    output logic [DW-1:0] recv_data_o,  // valid with recv_rdy_o only
    output logic          recv_rdy_o    // one-cycle receive pulse
);

    rx_state_e state;
    rx_state_e state_next;

    logic          req_d;      // first sync stage
    logic          req_s;      // synced req
    logic          ack;
    logic          recv_rdy;
    logic [DW-1:0] recv_data;

    // two-flop synchronizer on the incoming request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_d <= 1'b0;
            req_s <= 1'b0;
        end else begin
            req_d <= req_i;
            req_s <= req_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RX_IDLE: begin
                if (req_s) state_next = RX_DEASSERT;  // new word
            end
            RX_DEASSERT: begin
                if (!req_s) state_next = RX_IDLE;     // sender let go
            end
            default: begin
                state_next = RX_IDLE;                 // illegal code
            end
        endcase
    end

    // ack level, receive pulse and captured word
    // data is safe to sample here, the sender holds it while req is up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            recv_rdy  <= 1'b0;
            recv_data <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (req_s) begin
                        ack       <= 1'b1;
                        recv_rdy  <= 1'b1;        // single cycle
                        recv_data <= req_data_i;
                    end
                end
                RX_DEASSERT: begin
                    recv_rdy  <= 1'b0;
                    recv_data <= '0;              // back to idle value
                    if (!req_s) ack <= 1'b0;      // one cycle after req low
                end
                default: begin
                    ack       <= 1'b0;
                    recv_rdy  <= 1'b0;
                    recv_data <= '0;
                end
            endcase
        end
    end

    assign ack_o       = ack;
    assign recv_rdy_o  = recv_rdy;
    assign recv_data_o = recv_data;

endmodule

//--- source/handshake_cdc_top.sv
// top level of the clock domain crossing link
// sender runs on tx_clk_i / tx_rst_n_i, receiver on clk / rst_n
// one word crosses from send_i to recv_rdy_o at a time
// only req, req_data and ack pass between the two domains

`timescale 1ns/1ps

module handshake_cdc_top
    import hs_pkg::*;
#(
    parameter int DW = DATA_W  // word width, passed to both sides
) (
    input  logic          clk,          // receiving domain
    input  logic          rst_n,

    input  logic          tx_clk_i,     // sending domain
    input  logic          tx_rst_n_i,

    // sender side
    input  logic          send_i,
    input  logic [DW-1:0] send_data_i,
    output logic          busy_o,
    output logic          send_done_o,

    // receiver side
    output logic [DW-1:0] recv_data_o,
    output logic          recv_rdy_o
);

    logic          req;       // tx_clk_i domain level
    logic [DW-1:0] req_data;  // held by sender while req high
    logic          ack;       // clk domain level

    full_handshake_tx #(
        .DW (DW)
    ) u_tx (
        .clk         (tx_clk_i),
        .rst_n       (tx_rst_n_i),
        .send_i      (send_i),
        .send_data_i (send_data_i),
        .busy_o      (busy_o),
        .send_done_o (send_done_o),
        .req_o       (req),
        .req_data_o  (req_data),
        .ack_i       (ack)         // synced inside u_tx
    );

    full_handshake_rx #(
        .DW (DW)
    ) u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req),        // synced inside u_rx
        .req_data_i  (req_data),
        .ack_o       (ack),
        .recv_data_o (recv_data_o),
        .recv_rdy_o  (recv_rdy_o)
    );

endmodule

//--- bench/handshake_cdc_chk.sv
// protocol checker for the four-phase link
// bound into handshake_cdc_top, watches the crossing wires and the
// local pulses in both clock domains

`timescale 1ns/1ps

module handshake_cdc_chk #(
    parameter int DW = 32
) (
    input logic          clk,          // receiving domain
    input logic          rst_n,
    input logic          tx_clk_i,     // sending domain
    input logic          tx_rst_n_i,
    input logic          req_i,
    input logic [DW-1:0] req_data_i,
    input logic          ack_i,
    input logic          busy_i,
    input logic          send_done_i,
    input logic          recv_rdy_i
);

    // payload frozen for the whole request
    assert property (@(posedge tx_clk_i) disable iff (!tx_rst_n_i)
        req_i && $past(req_i) |-> req_data_i == $past(req_data_i))
    else $error("req_data changed while req high");

    // single cycle receive pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        recv_rdy_i |=> !recv_rdy_i)
    else $error("recv_rdy_o high for two clk cycles");

    // new request only once the old ack is gone
    assert property (@(posedge tx_clk_i) disable iff (!tx_rst_n_i)
        $rose(req_i) |-> !ack_i)
    else $error("req rose while ack high");

    assert property (@(posedge tx_clk_i) disable iff (!tx_rst_n_i)
        send_done_i |-> !busy_i)   // busy drops with done
    else $error("busy_o high during send_done_o");

endmodule

//--- bench/handshake_cdc_tb.sv
// testbench for the four-phase clock domain crossing link
// drives handshake_cdc_top from the tx_clk_i side with LFSR words and fixed
// patterns, checks every clk cycle of the receive outputs against a queue
// of accepted words, prints one line per test and a closing summary

`timescale 1ns/1ps

module handshake_cdc_tb
    import hs_pkg::*;
;

    localparam int  DW          = 32;
    localparam real CLK_PERIOD  = 4.0;   // receiving domain
    localparam real TX_PERIOD   = 7.0;   // sending domain, unrelated ratio
    localparam int  N_WORDS     = 77;    // 1 + 64 + 8 + 4 words in all tests
    localparam int  IDLE_CYCLES = 20;    // quiet window after reset
    localparam real TIMEOUT_NS  = (N_WORDS * 40 + IDLE_CYCLES + 20) * TX_PERIOD
                                  + 16 * CLK_PERIOD;

    logic          clk;
    logic          rst_n;
    logic          tx_clk_i;
    logic          tx_rst_n_i;
    logic          send_i;
    logic [DW-1:0] send_data_i;
    logic          busy_o;
    logic          send_done_o;
    logic [DW-1:0] recv_data_o;
    logic          recv_rdy_o;

    logic [DW-1:0] exp_q[$];       // accepted words, oldest first
    logic [31:0]   lfsr_state;
    logic          prev_rdy;       // recv_rdy_o one clk earlier
    logic          prev_done;      // send_done_o one tx cycle earlier
    int            err_stim;       // one counter per process
    int            err_recv;
    int            err_tx;
    int            accepted;
    int            recv_count;
    int            done_count;

    handshake_cdc_top #(
        .DW (DW)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_clk_i    (tx_clk_i),
        .tx_rst_n_i  (tx_rst_n_i),
        .send_i      (send_i),
        .send_data_i (send_data_i),
        .busy_o      (busy_o),
        .send_done_o (send_done_o),
        .recv_data_o (recv_data_o),
        .recv_rdy_o  (recv_rdy_o)
    );

    // protocol assertions on the internal crossing wires
    bind handshake_cdc_top handshake_cdc_chk #(
        .DW (DW)
    ) chk0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_clk_i    (tx_clk_i),
        .tx_rst_n_i  (tx_rst_n_i),
        .req_i       (req),
        .req_data_i  (req_data),
        .ack_i       (ack),
        .busy_i      (busy_o),
        .send_done_i (send_done_o),
        .recv_rdy_i  (recv_rdy_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;
    always #(TX_PERIOD / 2) tx_clk_i = ~tx_clk_i;

    // galois LFSR, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) s = s ^ 32'h8020_0003;
        return s;
    endfunction

    // one LFSR step per data bit
    task automatic next_word(output logic [DW-1:0] w);
        w = '0;
        for (int i = 0; i < DW; i++) begin
            w          = {w[DW-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // expected receive word: oldest accepted word during a pulse, else idle zero
    function automatic logic [DW-1:0] ref_recv(input logic pulse);
        if (pulse && exp_q.size() != 0) return exp_q[0];
        return '0;
    endfunction

    function automatic int total_errors();
        return err_stim + err_recv + err_tx;
    endfunction

    task automatic check_data(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act, inout int cnt);
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act,
                             inout int cnt);
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
            cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act,
                               inout int cnt);
        if (act != exp) begin
            $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
            cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (total_errors() == errs_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, total_errors() - errs_before);
    endtask

    // inputs change 1 ns after the tx edge
    task automatic tx_cycle();
        @(posedge tx_clk_i);
        #1;
    endtask

    // wait for an idle sender, then strobe one word
    task automatic send_word(input logic [DW-1:0] data);
        while (busy_o) tx_cycle();
        send_i      = 1'b1;
        send_data_i = data;
        exp_q.push_back(data);  // accepted at the coming edge
        accepted++;
        tx_cycle();
        check_bit("busy_o", 1'b1, busy_o, err_stim);  // high from next cycle
        send_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (busy_o || exp_q.size() != 0) tx_cycle();
        repeat (4) tx_cycle();
    endtask

    // receive side compare, outputs settle on posedge clk
    always @(negedge clk) begin
        if (recv_rdy_o) begin
            if (prev_rdy) check_bit("recv_rdy_o", 1'b0, recv_rdy_o, err_recv);
            if (exp_q.size() == 0) begin
                $display("receive pulse with no word outstanding at %0t", $time);
                err_recv++;
            end else begin
                check_data("recv_data_o", ref_recv(1'b1), recv_data_o, err_recv);
                exp_q.delete(0);
                recv_count++;
            end
        end else begin
            check_data("recv_data_o", ref_recv(1'b0), recv_data_o, err_recv);
        end
        prev_rdy = recv_rdy_o;
    end

    // send side pulses
    always @(negedge tx_clk_i) begin
        if (send_done_o) begin
            done_count++;
            check_bit("busy_o", 1'b0, busy_o, err_tx);          // falls with done
            if (prev_done) check_bit("send_done_o", 1'b0, send_done_o, err_tx);
        end
        prev_done = send_done_o;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: transfers did not finish within %0.1f ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [DW-1:0] word;
        logic [DW-1:0] junk;
        int            errs0;
        int            recv0;
        int            done0;
        int            acc0;
        int            ignored;

        clk         = 1'b0;
        tx_clk_i    = 1'b0;
        rst_n       = 1'b0;
        tx_rst_n_i  = 1'b0;
        send_i      = 1'b0;
        send_data_i = '0;
        lfsr_state  = 32'h6f7f_c1f2;
        prev_rdy    = 1'b0;
        prev_done   = 1'b0;
        err_stim    = 0;
        err_recv    = 0;
        err_tx      = 0;
        accepted    = 0;
        recv_count  = 0;
        done_count  = 0;
        ignored     = 0;

        repeat (16) @(posedge clk);
        #1;
        rst_n      = 1'b1;
        tx_rst_n_i = 1'b1;

        // 1: quiet outputs after reset
        errs0 = total_errors();
        repeat (IDLE_CYCLES) begin
            tx_cycle();
            check_bit("busy_o", 1'b0, busy_o, err_stim);
            check_bit("send_done_o", 1'b0, send_done_o, err_stim);
        end
        report_test("reset idle", errs0);

        // 2: one word from idle
        errs0 = total_errors();
        recv0 = recv_count;
        next_word(word);
        send_word(word);
        wait_drain();
        check_count("recv count", recv0 + 1, recv_count, err_stim);
        report_test("single word", errs0);

        // 3: back to back LFSR words
        errs0 = total_errors();
        recv0 = recv_count;
        done0 = done_count;
        repeat (64) begin
            next_word(word);
            send_word(word);
        end
        wait_drain();
        check_count("recv count", recv0 + 64, recv_count, err_stim);
        check_count("send_done count", done0 + 64, done_count, err_stim);
        report_test("stream of 64", errs0);

        // 4: strobes while busy must be dropped
        errs0 = total_errors();
        recv0 = recv_count;
        acc0  = accepted;
        repeat (8) begin
            next_word(word);
            send_word(word);
            while (busy_o) begin
                next_word(junk);
                if (junk == word) junk = ~junk;  // keep it distinct
                send_i      = 1'b1;
                send_data_i = junk;
                ignored++;
                tx_cycle();
            end
            send_i = 1'b0;
        end
        wait_drain();
        check_count("recv count", recv0 + (accepted - acc0), recv_count, err_stim);
        report_test("busy strobes", errs0);

        // 5: every bit held through the sync window
        errs0 = total_errors();
        recv0 = recv_count;
        send_word(32'h0000_0000);
        send_word(32'hffff_ffff);
        send_word(32'haaaa_aaaa);
        send_word(32'h5555_5555);
        wait_drain();
        check_count("recv count", recv0 + 4, recv_count, err_stim);
        report_test("bit patterns", errs0);

        $display("words accepted %0d, received %0d, done pulses %0d, dropped %0d, errors %0d",
                 accepted, recv_count, done_count, ignored, total_errors());
        if (total_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
source/hs_pkg.sv
source/full_handshake_tx.sv
source/full_handshake_rx.sv
source/handshake_cdc_top.sv
bench/handshake_cdc_chk.sv
bench/handshake_cdc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the handshake CDC testbench with Verilator.
# Exit status is 0 only when the log holds no failure line.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
TOP=handshake_cdc_tb
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    -f sim.f \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR" \
    -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure, log in $LOG"
exit 0
